//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- design/int_controller.sv
module int_controller #(
    parameter int NUM_OF_INTX = 2
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [NUM_OF_INTX-1:0] intx_i,
    input  logic                   t0_ovf_i,
    input  logic                   t1_ovf_i,
    input  sfr_map_pkg::sfr_data_t ie_i,
    input  sfr_map_pkg::sfr_data_t ip_i,
    input  logic                   interrupt_return_i,
    output logic                   int_gen_o,
    output int_pkg::int_vec_t      int_addr_o
);
    import sfr_map_pkg::*;
    import int_pkg::*;

    logic [NUM_OF_INTX-1:0] intx_meta;
    logic [NUM_OF_INTX-1:0] intx_sync;
    logic                   t0_pend;
    logic                   t1_pend;
    logic                   preempted_low;
    int_state_t             state_q;
    int_mask_t              pending;
    int_mask_t              eligible;
    int_mask_t              high_req;
    int_mask_t              low_req;
    int_mask_t              sel;
    int_mask_t              grant;
    logic                   issue;
    logic                   issue_high;
    int_vec_t               vec;

    // ========================================
    // Pin sync and timer pendings
    // ========================================
    // Pins idle high, so sync flops reset to 1
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            intx_meta <= '1;
            intx_sync <= '1;
        end else begin
            intx_meta <= intx_i;
            intx_sync <= intx_meta;
        end
    end

    // New overflow wins over the clear from its own vector
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            t0_pend <= 1'b0;
            t1_pend <= 1'b0;
        end else begin
            t0_pend <= (t0_pend & ~grant[INT_T0]) | t0_ovf_i;
            t1_pend <= (t1_pend & ~grant[INT_T1]) | t1_ovf_i;
        end
    end

    // Externals are level, active low
    always_comb begin
        pending           = '0;
        pending[INT_EXT0] = ~intx_sync[0];
        pending[INT_T0]   = t0_pend;
        pending[INT_EXT1] = ~intx_sync[1];
        pending[INT_T1]   = t1_pend;
    end

    assign eligible = pending & int_mask_t'(ie_i[NUM_OF_INT-1:0])
                    & {NUM_OF_INT{ie_i[IE_EA_INDEX]}};
    assign high_req = eligible & int_mask_t'(ip_i[NUM_OF_INT-1:0]);
    assign low_req  = eligible & ~int_mask_t'(ip_i[NUM_OF_INT-1:0]);

    // ========================================
    // Arbitration
    // ========================================
    // Nothing issues in a return cycle
    always_comb begin
        sel        = '0;
        issue_high = 1'b0;
        if (!interrupt_return_i) begin
            if ((state_q != HIGH_ACTIVE) && (|high_req)) begin
                sel        = high_req;
                issue_high = 1'b1;
            end else if (state_q == IDLE) begin
                sel = low_req;
            end
        end
    end

    // Lowest index wins, isolate lowest set bit
    assign grant = sel & (~sel + int_mask_t'(1));
    assign issue = |grant;

    always_comb begin
        vec = '0;
        for (int i = 0; i < NUM_OF_INT; i++) begin
            if (grant[i]) begin
                vec = INT_VECTOR[i];
            end
        end
    end

    // ========================================
    // Nesting FSM and outputs
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q       <= IDLE;
            preempted_low <= 1'b0;
        end else if (interrupt_return_i) begin
            case (state_q)
                HIGH_ACTIVE: state_q <= preempted_low ? LOW_ACTIVE : IDLE;
                LOW_ACTIVE:  state_q <= IDLE;
                default:     state_q <= IDLE;
            endcase
        end else if (issue) begin
            if (issue_high) begin
                state_q       <= HIGH_ACTIVE;
                // Remember the level to drop back to
                preempted_low <= (state_q == LOW_ACTIVE);
            end else begin
                state_q <= LOW_ACTIVE;
            end
        end
    end

    // Vector holds until the next issue
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            int_gen_o  <= 1'b0;
            int_addr_o <= '0;
        end else begin
            int_gen_o <= issue;
            if (issue) begin
                int_addr_o <= vec;
            end
        end
    end

endmodule

//--- design/int_pkg.sv
package int_pkg;

    // ========================================
    // Interrupt sources
    // ========================================
    localparam int NUM_OF_INT = 4;

    // Source order, also the IE/IP bit order
    localparam int INT_EXT0 = 0;
    localparam int INT_T0   = 1;
    localparam int INT_EXT1 = 2;
    localparam int INT_T1   = 3;

    typedef logic [NUM_OF_INT-1:0] int_mask_t;
    typedef logic [7:0]            int_vec_t;

    // Classic vector per source index
    localparam int_vec_t INT_VECTOR [NUM_OF_INT] = '{8'h03, 8'h0B, 8'h13, 8'h1B};

    // Nesting level of the interrupt in service
    typedef enum logic [1:0] {
        IDLE,
        LOW_ACTIVE,
        HIGH_ACTIVE
    } int_state_t;

endpackage

//--- design/peripherals_top.sv
module peripherals_top #(
    parameter int NUM_OF_INTX = 2
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic [NUM_OF_INTX-1:0] intx_i,
    input  logic                   interrupt_return_i,
    input  logic                   wr_stb_i,
    input  logic                   wr_we_i,
    input  sfr_map_pkg::sfr_addr_t wr_adr_i,
    input  sfr_map_pkg::sfr_data_t wr_dat_i,
    input  logic                   rd_stb_i,
    input  sfr_map_pkg::sfr_addr_t rd_adr_i,
    input  logic                   timer_event_pulse_i,
    output sfr_map_pkg::sfr_data_t rd_dat_o,
    output logic                   rd_ack_o,
    output logic                   wr_ack_o,
    output int_pkg::int_vec_t      int_addr_o,
    output logic                   int_gen_o,
    output logic                   timer_pulse_out_o
);
    import sfr_map_pkg::*;

    logic      we_ie, we_ip, we_tmod, we_tcon;
    logic      we_tl0, we_th0, we_tl1, we_th1;
    sfr_sel_t  rd_sel;
    sfr_data_t ie, ip, tmod, tcon;
    sfr_data_t tl0, th0, tl1, th1;
    logic      t0_ovf, t1_ovf;

    // No wait states on either port
    assign wr_ack_o = wr_stb_i;
    assign rd_ack_o = rd_stb_i;

    // ========================================
    // Decode
    // ========================================
    sfr_decode u_decode (
        .wr_stb_i (wr_stb_i),  .wr_we_i  (wr_we_i),
        .wr_adr_i (wr_adr_i),  .rd_adr_i (rd_adr_i),
        .we_ie_o  (we_ie),     .we_ip_o  (we_ip),
        .we_tmod_o(we_tmod),   .we_tcon_o(we_tcon),
        .we_tl0_o (we_tl0),    .we_th0_o (we_th0),
        .we_tl1_o (we_tl1),    .we_th1_o (we_th1),
        .rd_sel_o (rd_sel)
    );

    // ========================================
    // Execute
    // ========================================
    sfr_control_regs u_regs (
        .clk      (clk),       .reset_n  (reset_n),
        .wr_dat_i (wr_dat_i),
        .we_ie_i  (we_ie),     .we_ip_i  (we_ip),
        .we_tmod_i(we_tmod),   .we_tcon_i(we_tcon),
        .tf0_set_i(t0_ovf),    .tf1_set_i(t1_ovf),
        .ie_o     (ie),        .ip_o     (ip),
        .tmod_o   (tmod),      .tcon_o   (tcon)
    );

    // TMOD low nibble is timer 0: GATE C/T M1 M0
    timer_8051 timer0 (
        .clk (clk), .reset_n (reset_n), .wr_dat_i (wr_dat_i),
        .we_tl_i (we_tl0), .we_th_i (we_th0),
        .run_i (tcon[TCON_TR0_INDEX]), .counter_mode_i (tmod[2]),
        .mode_i (timer_mode_t'(tmod[1:0])),
        .timer_event_pulse_i (timer_event_pulse_i),
        .tl_o (tl0), .th_o (th0), .overflow_o (t0_ovf)
    );

    // High nibble is timer 1
    timer_8051 timer1 (
        .clk (clk), .reset_n (reset_n), .wr_dat_i (wr_dat_i),
        .we_tl_i (we_tl1), .we_th_i (we_th1),
        .run_i (tcon[TCON_TR1_INDEX]), .counter_mode_i (tmod[6]),
        .mode_i (timer_mode_t'(tmod[5:4])),
        .timer_event_pulse_i (timer_event_pulse_i),
        .tl_o (tl1), .th_o (th1), .overflow_o (t1_ovf)
    );

    int_controller #(.NUM_OF_INTX(NUM_OF_INTX)) u_int (
        .clk (clk), .reset_n (reset_n), .intx_i (intx_i),
        .t0_ovf_i (t0_ovf), .t1_ovf_i (t1_ovf),
        .ie_i (ie), .ip_i (ip),
        .interrupt_return_i (interrupt_return_i),
        .int_gen_o (int_gen_o), .int_addr_o (int_addr_o)
    );

    // Square wave at half the timer 0 overflow rate
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            timer_pulse_out_o <= 1'b0;
        end else if (t0_ovf) begin
            timer_pulse_out_o <= ~timer_pulse_out_o;
        end
    end

    // ========================================
    // Result
    // ========================================
    sfr_read_mux u_rd_mux (
        .rd_sel_i (rd_sel),
        .ie_i (ie), .ip_i (ip), .tmod_i (tmod), .tcon_i (tcon),
        .tl0_i (tl0), .th0_i (th0), .tl1_i (tl1), .th1_i (th1),
        .rd_dat_o (rd_dat_o)
    );

endmodule

//--- design/sfr_control_regs.sv
module sfr_control_regs (
    input  logic                   clk,
    input  logic                   reset_n,
    input  sfr_map_pkg::sfr_data_t wr_dat_i,
    input  logic                   we_ie_i,
    input  logic                   we_ip_i,
    input  logic                   we_tmod_i,
    input  logic                   we_tcon_i,
    input  logic                   tf0_set_i,
    input  logic                   tf1_set_i,
    output sfr_map_pkg::sfr_data_t ie_o,
    output sfr_map_pkg::sfr_data_t ip_o,
    output sfr_map_pkg::sfr_data_t tmod_o,
    output sfr_map_pkg::sfr_data_t tcon_o
);
    import sfr_map_pkg::*;

    // Overflow flags raised by the timers this cycle
    sfr_data_t tf_set_mask;

    always_comb begin
        tf_set_mask = '0;
        tf_set_mask[TCON_TF0_INDEX] = tf0_set_i;
        tf_set_mask[TCON_TF1_INDEX] = tf1_set_i;
    end

    // ========================================
    // IE, IP, TMOD
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ie_o   <= '0;
            ip_o   <= '0;
            tmod_o <= '0;
        end else begin
            if (we_ie_i) begin
                ie_o <= wr_dat_i;
            end
            if (we_ip_i) begin
                ip_o <= wr_dat_i;
            end
            // GATE bits land here too, nothing looks at them
            if (we_tmod_i) begin
                tmod_o <= wr_dat_i;
            end
        end
    end

    // ========================================
    // TCON
    // ========================================
    // Bus write beats a same-cycle overflow
    // Software clears TF by writing 0
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tcon_o <= '0;
        end else if (we_tcon_i) begin
            tcon_o <= wr_dat_i;
        end else begin
            tcon_o <= tcon_o | tf_set_mask;
        end
    end

endmodule

//--- design/sfr_decode.sv
module sfr_decode (
    input  logic                   wr_stb_i,
    input  logic                   wr_we_i,
    input  sfr_map_pkg::sfr_addr_t wr_adr_i,
    input  sfr_map_pkg::sfr_addr_t rd_adr_i,
    output logic                   we_ie_o,
    output logic                   we_ip_o,
    output logic                   we_tmod_o,
    output logic                   we_tcon_o,
    output logic                   we_tl0_o,
    output logic                   we_th0_o,
    output logic                   we_tl1_o,
    output logic                   we_th1_o,
    output sfr_map_pkg::sfr_sel_t  rd_sel_o
);
    import sfr_map_pkg::*;

    // Write only when both strobes are up
    logic wr_valid;

    assign wr_valid = wr_stb_i & wr_we_i;

    // One-hot write enables
    always_comb begin
        we_ie_o   = 1'b0;
        we_ip_o   = 1'b0;
        we_tmod_o = 1'b0;
        we_tcon_o = 1'b0;
        we_tl0_o  = 1'b0;
        we_th0_o  = 1'b0;
        we_tl1_o  = 1'b0;
        we_th1_o  = 1'b0;
        if (wr_valid) begin
            case (wr_adr_i)
                IE_ADDR:   we_ie_o   = 1'b1;
                IP_ADDR:   we_ip_o   = 1'b1;
                TMOD_ADDR: we_tmod_o = 1'b1;
                TCON_ADDR: we_tcon_o = 1'b1;
                TL0_ADDR:  we_tl0_o  = 1'b1;
                TH0_ADDR:  we_th0_o  = 1'b1;
                TL1_ADDR:  we_tl1_o  = 1'b1;
                TH1_ADDR:  we_th1_o  = 1'b1;
                default: ;
            endcase
        end
    end

    // Read select, unmapped falls to SEL_NONE
    always_comb begin
        case (rd_adr_i)
            IE_ADDR:   rd_sel_o = SEL_IE;
            IP_ADDR:   rd_sel_o = SEL_IP;
            TMOD_ADDR: rd_sel_o = SEL_TMOD;
            TCON_ADDR: rd_sel_o = SEL_TCON;
            TL0_ADDR:  rd_sel_o = SEL_TL0;
            TH0_ADDR:  rd_sel_o = SEL_TH0;
            TL1_ADDR:  rd_sel_o = SEL_TL1;
            TH1_ADDR:  rd_sel_o = SEL_TH1;
            default:   rd_sel_o = SEL_NONE;
        endcase
    end

endmodule

//--- design/sfr_map_pkg.sv
package sfr_map_pkg;

    // ========================================
    // Data and address types
    // ========================================
    typedef logic [7:0] sfr_data_t;
    typedef logic [7:0] sfr_addr_t;

    // SFR addresses, classic 8051 map
    localparam sfr_addr_t TCON_ADDR = 8'h88;
    localparam sfr_addr_t TMOD_ADDR = 8'h89;
    localparam sfr_addr_t TL0_ADDR  = 8'h8A;
    localparam sfr_addr_t TL1_ADDR  = 8'h8B;
    localparam sfr_addr_t TH0_ADDR  = 8'h8C;
    localparam sfr_addr_t TH1_ADDR  = 8'h8D;
    localparam sfr_addr_t IE_ADDR   = 8'hA8;
    localparam sfr_addr_t IP_ADDR   = 8'hB8;

    // TCON fields, IT/IE bits 3..0 are plain storage
    localparam int TCON_TF1_INDEX = 7;
    localparam int TCON_TR1_INDEX = 6;
    localparam int TCON_TF0_INDEX = 5;
    localparam int TCON_TR0_INDEX = 4;

    // Global enable in IE
    localparam int IE_EA_INDEX = 7;

    // TMOD M1:M0 encoding, mode 3 not supported
    typedef enum logic [1:0] {
        MODE_13BIT       = 2'd0,
        MODE_16BIT       = 2'd1,
        MODE_8BIT_RELOAD = 2'd2,
        MODE_UNUSED      = 2'd3
    } timer_mode_t;

    // Readable register picked by the read address
    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_IE,
        SEL_IP,
        SEL_TMOD,
        SEL_TCON,
        SEL_TL0,
        SEL_TH0,
        SEL_TL1,
        SEL_TH1
    } sfr_sel_t;

endpackage

//--- design/sfr_read_mux.sv
module sfr_read_mux (
    input  sfr_map_pkg::sfr_sel_t  rd_sel_i,
    input  sfr_map_pkg::sfr_data_t ie_i,
    input  sfr_map_pkg::sfr_data_t ip_i,
    input  sfr_map_pkg::sfr_data_t tmod_i,
    input  sfr_map_pkg::sfr_data_t tcon_i,
    input  sfr_map_pkg::sfr_data_t tl0_i,
    input  sfr_map_pkg::sfr_data_t th0_i,
    input  sfr_map_pkg::sfr_data_t tl1_i,
    input  sfr_map_pkg::sfr_data_t th1_i,
    output sfr_map_pkg::sfr_data_t rd_dat_o
);
    import sfr_map_pkg::*;

    // Same-cycle read data, unmapped reads 00h
    always_comb begin
        case (rd_sel_i)
            SEL_IE:   rd_dat_o = ie_i;
            SEL_IP:   rd_dat_o = ip_i;
            SEL_TMOD: rd_dat_o = tmod_i;
            SEL_TCON: rd_dat_o = tcon_i;
            SEL_TL0:  rd_dat_o = tl0_i;
            SEL_TH0:  rd_dat_o = th0_i;
            SEL_TL1:  rd_dat_o = tl1_i;
            SEL_TH1:  rd_dat_o = th1_i;
            SEL_NONE: rd_dat_o = '0;
            default:  rd_dat_o = '0;
        endcase
    end

endmodule

//--- design/timer_8051.sv
module timer_8051 (
    input  logic                     clk,
    input  logic                     reset_n,
    input  sfr_map_pkg::sfr_data_t   wr_dat_i,
    input  logic                     we_tl_i,
    input  logic                     we_th_i,
    input  logic                     run_i,
    input  logic                     counter_mode_i,
    input  sfr_map_pkg::timer_mode_t mode_i,
    input  logic                     timer_event_pulse_i,
    output sfr_map_pkg::sfr_data_t   tl_o,
    output sfr_map_pkg::sfr_data_t   th_o,
    output logic                     overflow_o
);
    import sfr_map_pkg::*;

    logic      inc;
    logic      at_max;
    sfr_data_t tl_next;
    sfr_data_t th_next;

    // Clock tick in timer mode, event tick in counter mode
    assign inc = run_i & (counter_mode_i ? timer_event_pulse_i : 1'b1);

    // ========================================
    // Next count per mode
    // ========================================
    always_comb begin
        at_max  = 1'b0;
        tl_next = tl_o;
        th_next = th_o;
        case (mode_i)
            MODE_13BIT: begin
                // TH:TL[4:0], TL[7:5] left alone
                at_max = (th_o == 8'hFF) && (tl_o[4:0] == 5'h1F);
                {th_next, tl_next[4:0]} = {th_o, tl_o[4:0]} + 13'd1;
            end
            MODE_16BIT: begin
                at_max = ({th_o, tl_o} == 16'hFFFF);
                {th_next, tl_next} = {th_o, tl_o} + 16'd1;
            end
            MODE_8BIT_RELOAD: begin
                // TL wraps back to TH
                at_max  = (tl_o == 8'hFF);
                tl_next = at_max ? th_o : tl_o + 8'd1;
            end
            MODE_UNUSED: begin
                // Timer holds
            end
        endcase
    end

    // Pulse in the counting cycle that wraps
    assign overflow_o = inc & at_max;

    // ========================================
    // Count registers
    // ========================================
    // Bus write takes the byte over the count
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tl_o <= '0;
            th_o <= '0;
        end else begin
            if (we_tl_i) begin
                tl_o <= wr_dat_i;
            end else if (inc) begin
                tl_o <= tl_next;
            end
            if (we_th_i) begin
                th_o <= wr_dat_i;
            end else if (inc) begin
                th_o <= th_next;
            end
        end
    end

endmodule

//--- dv/peripherals_properties.sv
module peripherals_properties (
    input logic                   clk,
    input logic                   reset_n,
    input logic                   interrupt_return_i,
    input logic                   wr_stb_i,
    input logic                   wr_we_i,
    input sfr_map_pkg::sfr_addr_t wr_adr_i,
    input sfr_map_pkg::sfr_data_t wr_dat_i,
    input logic                   rd_stb_i,
    input sfr_map_pkg::sfr_addr_t rd_adr_i,
    input logic                   timer_event_pulse_i,
    input sfr_map_pkg::sfr_data_t rd_dat_o,
    input logic                   rd_ack_o,
    input logic                   wr_ack_o,
    input int_pkg::int_vec_t      int_addr_o,
    input logic                   int_gen_o,
    input logic                   timer_pulse_out_o
);
    import sfr_map_pkg::*;
    import int_pkg::*;

    // Bumped by every failing assertion, watched by tb_top
    int fail_count;

    // Expected register contents, built from bus traffic
    sfr_data_t   ie_m, ip_m, tmod_m, tcon_m;
    sfr_data_t   tl0_m, th0_m, tl1_m, th1_m;
    sfr_data_t   exp_rd;
    logic [15:0] t0_n, t1_n;
    logic        wr, inc0, inc1, ovf0, ovf1;
    logic        exp_pulse;
    logic        from_low;
    logic [1:0]  idx;
    int_state_t  lvl;

    // Next {TH, TL} after one count in modes 1 and 2
    function automatic logic [15:0] count_once(input logic [1:0] mode,
                                               input sfr_data_t th, input sfr_data_t tl);
        logic [15:0] res;
        res = {th, tl};
        if (mode == 2'd1) begin
            res = {th, tl} + 16'd1;
        end else if (mode == 2'd2) begin
            res = (tl == 8'hFF) ? {th, th} : {th, tl + 8'd1};
        end
        return res;
    endfunction

    assign wr   = wr_stb_i & wr_we_i;
    assign inc0 = tcon_m[TCON_TR0_INDEX] & (tmod_m[2] ? timer_event_pulse_i : 1'b1);
    assign inc1 = tcon_m[TCON_TR1_INDEX] & (tmod_m[6] ? timer_event_pulse_i : 1'b1);

    // Wrap from all ones, width by mode
    assign ovf0 = inc0 & ((tmod_m[1:0] == 2'd1) ? ({th0_m, tl0_m} == 16'hFFFF)
                        : (tmod_m[1:0] == 2'd2) ? (tl0_m == 8'hFF) : 1'b0);
    assign ovf1 = inc1 & ((tmod_m[5:4] == 2'd1) ? ({th1_m, tl1_m} == 16'hFFFF)
                        : (tmod_m[5:4] == 2'd2) ? (tl1_m == 8'hFF) : 1'b0);

    assign t0_n = inc0 ? count_once(tmod_m[1:0], th0_m, tl0_m) : {th0_m, tl0_m};
    assign t1_n = inc1 ? count_once(tmod_m[5:4], th1_m, tl1_m) : {th1_m, tl1_m};

    // Source index from vector 8n+3
    assign idx = int_addr_o[4:3];

    always_comb begin
        case (rd_adr_i)
            IE_ADDR:   exp_rd = ie_m;
            IP_ADDR:   exp_rd = ip_m;
            TMOD_ADDR: exp_rd = tmod_m;
            TCON_ADDR: exp_rd = tcon_m;
            TL0_ADDR:  exp_rd = tl0_m;
            TH0_ADDR:  exp_rd = th0_m;
            TL1_ADDR:  exp_rd = tl1_m;
            TH1_ADDR:  exp_rd = th1_m;
            default:   exp_rd = 8'h00;
        endcase
    end

    // ========================================
    // Reference state
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ie_m      <= '0;
            ip_m      <= '0;
            tmod_m    <= '0;
            tcon_m    <= '0;
            {th0_m, tl0_m} <= '0;
            {th1_m, tl1_m} <= '0;
            exp_pulse <= 1'b0;
            lvl       <= IDLE;
            from_low  <= 1'b0;
        end else begin
            if (wr && wr_adr_i == IE_ADDR)   ie_m   <= wr_dat_i;
            if (wr && wr_adr_i == IP_ADDR)   ip_m   <= wr_dat_i;
            if (wr && wr_adr_i == TMOD_ADDR) tmod_m <= wr_dat_i;
            // Bus write beats the flag
            if (wr && wr_adr_i == TCON_ADDR) begin
                tcon_m <= wr_dat_i;
            end else begin
                tcon_m <= tcon_m | {ovf1, 1'b0, ovf0, 5'b0};
            end
            tl0_m <= (wr && wr_adr_i == TL0_ADDR) ? wr_dat_i : t0_n[7:0];
            th0_m <= (wr && wr_adr_i == TH0_ADDR) ? wr_dat_i : t0_n[15:8];
            tl1_m <= (wr && wr_adr_i == TL1_ADDR) ? wr_dat_i : t1_n[7:0];
            th1_m <= (wr && wr_adr_i == TH1_ADDR) ? wr_dat_i : t1_n[15:8];
            exp_pulse <= exp_pulse ^ ovf0;
            // Nesting level seen from the issued vectors
            if (interrupt_return_i) begin
                lvl <= (lvl == HIGH_ACTIVE && from_low) ? LOW_ACTIVE : IDLE;
            end else if (int_gen_o) begin
                if (ip_m[idx]) begin
                    from_low <= (lvl == LOW_ACTIVE);
                    lvl      <= HIGH_ACTIVE;
                end else begin
                    lvl <= LOW_ACTIVE;
                end
            end
        end
    end

    // ========================================
    // Assertions
    // ========================================
    ack_follows_stb: assert property (@(posedge clk) disable iff (!reset_n)
        wr_ack_o == wr_stb_i && rd_ack_o == rd_stb_i)
    else begin
        $error("[FAIL] ack: wr_ack_o=%h wr_stb_i=%h rd_ack_o=%h rd_stb_i=%h",
               $sampled(wr_ack_o), $sampled(wr_stb_i),
               $sampled(rd_ack_o), $sampled(rd_stb_i));
        fail_count++;
    end

    read_data: assert property (@(posedge clk) disable iff (!reset_n)
        rd_stb_i |-> rd_dat_o == exp_rd)
    else begin
        $error("[FAIL] rd_dat_o=%h expected %h at address %h",
               $sampled(rd_dat_o), $sampled(exp_rd), $sampled(rd_adr_i));
        fail_count++;
    end

    pulse_toggle: assert property (@(posedge clk) disable iff (!reset_n)
        timer_pulse_out_o == exp_pulse)
    else begin
        $error("[FAIL] timer_pulse_out_o=%h expected %h",
               $sampled(timer_pulse_out_o), $sampled(exp_pulse));
        fail_count++;
    end

    // Classic vectors sit at 8n+3
    vector_value: assert property (@(posedge clk) disable iff (!reset_n)
        int_gen_o |-> int_addr_o == {3'b000, idx, 3'b011})
    else begin
        $error("[FAIL] int_addr_o=%h expected %h",
               $sampled(int_addr_o), {3'b000, $sampled(idx), 3'b011});
        fail_count++;
    end

    int_enabled: assert property (@(posedge clk) disable iff (!reset_n)
        int_gen_o |-> ie_m[IE_EA_INDEX] && ie_m[idx])
    else begin
        $error("[FAIL] int_addr_o=%h issued with IE=%h",
               $sampled(int_addr_o), $sampled(ie_m));
        fail_count++;
    end

    low_from_idle: assert property (@(posedge clk) disable iff (!reset_n)
        int_gen_o && !ip_m[idx] |-> lvl == IDLE)
    else begin
        $error("Low priority interrupt issued while another was in service");
        fail_count++;
    end

    high_not_nested: assert property (@(posedge clk) disable iff (!reset_n)
        int_gen_o && ip_m[idx] |-> lvl != HIGH_ACTIVE)
    else begin
        $error("High priority interrupt issued during a high priority one");
        fail_count++;
    end

    vector_hold: assert property (@(posedge clk) disable iff (!reset_n)
        !int_gen_o |-> $stable(int_addr_o))
    else begin
        $error("[FAIL] int_addr_o=%h changed without int_gen_o", $sampled(int_addr_o));
        fail_count++;
    end

endmodule

bind peripherals_top peripherals_properties u_props (.*);

//--- dv/tb_top.sv
module tb_top;
    import sfr_map_pkg::*;

    localparam int NUM_OF_INTX     = 2;
    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int WATCHDOG_CYCLES = 4000;
    localparam int INT_WAIT_MAX    = 200;

    logic                   clk = 1'b0;
    logic                   reset_n;
    logic [NUM_OF_INTX-1:0] intx_i;
    logic                   interrupt_return_i;
    logic                   wr_stb_i, wr_we_i, rd_stb_i;
    sfr_addr_t              wr_adr_i, rd_adr_i;
    sfr_data_t              wr_dat_i, rd_dat_o;
    logic                   timer_event_pulse_i;
    logic                   rd_ack_o, wr_ack_o, int_gen_o, timer_pulse_out_o;
    logic [7:0]             int_addr_o;

    always #(CLK_PERIOD / 2) clk = ~clk;

    peripherals_top #(.NUM_OF_INTX(NUM_OF_INTX)) DUT (.*);

    // Tasks start and end 1 unit after a rising edge
    task automatic write_sfr(input sfr_addr_t adr, input sfr_data_t dat);
        wr_stb_i = 1'b1;
        wr_we_i  = 1'b1;
        wr_adr_i = adr;
        wr_dat_i = dat;
        @(posedge clk);
        #1;
        wr_stb_i = 1'b0;
        wr_we_i  = 1'b0;
    endtask

    task automatic read_sfr(input sfr_addr_t adr);
        rd_stb_i = 1'b1;
        rd_adr_i = adr;
        @(posedge clk);
        #1;
        rd_stb_i = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic pulse_return();
        interrupt_return_i = 1'b1;
        idle(1);
        interrupt_return_i = 1'b0;
    endtask

    task automatic await_interrupt(input string what);
        int waited;
        waited = 0;
        while (!int_gen_o) begin
            idle(1);
            waited++;
            if (waited > INT_WAIT_MAX) begin
                $display("Simulation failed");
                $fatal(1, "No interrupt issued for %s", what);
            end
        end
        idle(1);
    endtask

    // Load timer 0 and let it run to overflow
    task automatic run_timer0(input sfr_data_t tmod, input sfr_data_t th,
                              input sfr_data_t tl, input int cycles);
        write_sfr(TMOD_ADDR, tmod);
        write_sfr(TH0_ADDR, th);
        write_sfr(TL0_ADDR, tl);
        write_sfr(TCON_ADDR, 8'h10);
        idle(cycles);
        read_sfr(TCON_ADDR);
        write_sfr(TCON_ADDR, 8'h00);
    endtask

    // First failing assertion ends the run
    always @(posedge clk) begin
        if (DUT.u_props.fail_count != 0) begin
            $display("Simulation failed");
            $fatal(1, "Assertion failure in the bound checker");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired before the tests finished");
    end

    initial begin
        sfr_addr_t regs [3];
        int        n;
        regs = '{IE_ADDR, IP_ADDR, TMOD_ADDR};
        void'($urandom(95));
        reset_n             = 1'b0;
        intx_i              = '1;
        interrupt_return_i  = 1'b0;
        wr_stb_i            = 1'b0;
        wr_we_i             = 1'b0;
        wr_adr_i            = '0;
        wr_dat_i            = '0;
        rd_stb_i            = 1'b0;
        rd_adr_i            = '0;
        timer_event_pulse_i = 1'b0;
        idle(RESET_CYCLES);
        reset_n = 1'b1;
        idle(2);

        // ========================================
        // Register readback and unmapped reads
        // ========================================
        for (int i = 0; i < 6; i++) begin
            write_sfr(regs[i % 3], sfr_data_t'($urandom));
            read_sfr(regs[i % 3]);
        end
        read_sfr(8'h00);
        read_sfr(8'h90);
        read_sfr(8'hFF);
        write_sfr(IE_ADDR, 8'h00);
        write_sfr(IP_ADDR, 8'h00);

        // Mode 1 overflow from FFF0h
        run_timer0(8'h01, 8'hFF, 8'hF0, 16);

        // Mode 2 reload on timer 1
        write_sfr(TMOD_ADDR, 8'h20);
        write_sfr(TH1_ADDR, 8'hC0);
        write_sfr(TL1_ADDR, 8'hFE);
        write_sfr(TCON_ADDR, 8'h40);
        idle(5);
        read_sfr(TL1_ADDR);
        read_sfr(TCON_ADDR);
        write_sfr(TCON_ADDR, 8'h00);

        // Counter mode, events only
        write_sfr(TMOD_ADDR, 8'h05);
        write_sfr(TH0_ADDR, 8'h00);
        write_sfr(TL0_ADDR, 8'h00);
        write_sfr(TCON_ADDR, 8'h10);
        n = 3 + int'($urandom % 6);
        repeat (n) begin
            timer_event_pulse_i = 1'b1;
            idle(1);
            timer_event_pulse_i = 1'b0;
            idle(2);
        end
        read_sfr(TL0_ADDR);
        write_sfr(TCON_ADDR, 8'h00);

        // ========================================
        // Vectors and enables
        // ========================================
        write_sfr(IE_ADDR, 8'h02);
        run_timer0(8'h01, 8'hFF, 8'hF8, 30);
        write_sfr(IE_ADDR, 8'h82);
        await_interrupt("timer 0");
        pulse_return();
        write_sfr(IE_ADDR, 8'h84);
        intx_i[1] = 1'b0;
        await_interrupt("external 1");
        intx_i[1] = 1'b1;
        idle(4);
        pulse_return();

        // Nesting, external 0 high over timer 0 low
        // Timer 0 stays pending until its enable goes up
        write_sfr(IP_ADDR, 8'h01);
        run_timer0(8'h01, 8'hFF, 8'hFE, 4);
        write_sfr(IE_ADDR, 8'h83);
        await_interrupt("low timer 0");
        intx_i[0] = 1'b0;
        await_interrupt("high external 0");
        intx_i[0] = 1'b1;
        run_timer0(8'h01, 8'hFF, 8'hFE, 4);
        idle(4);
        pulse_return();
        idle(6);
        pulse_return();
        await_interrupt("second timer 0");
        pulse_return();
        idle(5);

        if (DUT.u_props.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "Checker reported failures");
        end
    end

endmodule

//--- tb.f
design/sfr_map_pkg.sv
design/int_pkg.sv
design/sfr_decode.sv
design/sfr_control_regs.sv
design/timer_8051.sv
design/int_controller.sv
design/sfr_read_mux.sv
design/peripherals_top.sv
dv/peripherals_properties.sv
dv/tb_top.sv
